// ==== rv64_slice.f ====
+incdir+source
source/rv64_pkg.sv
source/rv64_mul_if.sv
source/rv64_decode.sv
source/rv64_regfile.sv
source/rv64_stage_reg.sv
source/rv64_mul.sv
source/rv64_execute.sv
source/rv64_slice.sv
dv/rv64_slice_properties.sv
dv/rv64_slice_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -Wno-fatal -f rv64_slice.f \
		--top-module rv64_slice_tb -Mdir obj_dir
	./obj_dir/Vrv64_slice_tb | tee $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/rv64_slice_tb.sv ====
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_slice_tb;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic in_valid = 1'b0;
	logic [31:0] in_instr = '0;
	logic [`XLEN-1:0] in_pc = '0;
	logic in_ready, out_valid, out_we, out_illegal;
	logic [`XLEN-1:0] out_pc, out_data, out_next_pc;
	logic [4:0] out_rd;

	logic [31:0] rng = 32'h4250_e093;
	logic [31:0] seq = '0;
	logic [63:0] regs [32];
	rv64_pkg::retire_t exp_q [$];
	int value_err = 0;
	int other_err = 0;
	int cycle = 0;
	int due = -1;
	int accepted_n = 0;
	int retired_n = 0;
	bit stop = 0;

	rv64_slice dut_i (.*);

	always #5 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// ============================================================
	// Reference model of the supported RV64IM subset.
	// ============================================================
	function automatic logic [63:0] alu64(input logic [2:0] f3, input logic alt,
	                                      input logic [63:0] a, input logic [63:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[5:0];
			3'd2: return {63'b0, $signed(a) < $signed(b)};
			3'd3: return {63'b0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[5:0];
				return a >> b[5:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] alu32(input logic [2:0] f3, input logic alt,
	                                      input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			default: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
		endcase
	endfunction

	function automatic rv64_pkg::retire_t model_exec(input logic [31:0] ins,
	                                                 input logic [63:0] pc);
		rv64_pkg::retire_t r;
		logic [2:0] f3;
		logic [63:0] a, b, ii, res;
		logic [31:0] w;
		logic ok, taken;
		f3 = ins[14:12];
		a = (ins[19:15] == 5'd0) ? 64'd0 : regs[ins[19:15]];
		b = (ins[24:20] == 5'd0) ? 64'd0 : regs[ins[24:20]];
		ii = {{52{ins[31]}}, ins[31:20]};
		ok = 1'b1;
		res = '0;
		w = '0;
		taken = 1'b0;
		r.next_pc = pc + 64'd4;
		case (ins[6:0])
			`OPC_LUI:   res = {{32{ins[31]}}, ins[31:12], 12'b0};
			`OPC_AUIPC: res = pc + {{32{ins[31]}}, ins[31:12], 12'b0};
			`OPC_JAL: begin
				res = pc + 64'd4;
				r.next_pc = pc + {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			`OPC_JALR: begin
				res = pc + 64'd4;
				r.next_pc = (a + ii) & ~64'd1;
			end
			`OPC_BRANCH: begin
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = ($signed(a) < $signed(b));
					3'd5: taken = ($signed(a) >= $signed(b));
					3'd6: taken = (a < b);
					default: taken = (a >= b);
				endcase
				if (taken)
					r.next_pc = pc + {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			end
			`OPC_OP_IMM: res = alu64(f3, ins[30] && f3 == 3'd5, a, ii);
			`OPC_OP_IMM_32: begin
				w = alu32(f3, ins[30] && f3 == 3'd5, a[31:0], ii[31:0]);
				res = {{32{w[31]}}, w};
			end
			`OPC_OP: begin
				if (ins[25])
					ok = (f3 == 3'd0);
				res = ins[25] ? a * b : alu64(f3, ins[30], a, b);
			end
			`OPC_OP_32: begin
				if (ins[25])
					ok = (f3 == 3'd0);
				w = ins[25] ? a[31:0] * b[31:0] : alu32(f3, ins[30], a[31:0], b[31:0]);
				res = {{32{w[31]}}, w};
			end
			default: ok = 1'b0;
		endcase
		r.pc = pc;
		r.rd = ins[11:7];
		r.illegal = !ok;
		r.we = ok && ins[6:0] != `OPC_BRANCH && ins[11:7] != 5'd0;
		r.data = res;
		if (r.we)
			regs[r.rd] = res;
		return r;
	endfunction

	// ============================================================
	// Compare tasks.
	// ============================================================
	task automatic value_mismatch(input string name, input logic [63:0] e, input logic [63:0] g);
		value_err++;
		$display("ERR t=%0t %s expected %h got %h", $time, name, e, g);
	endtask

	task automatic check_flag(input string name, input logic e, input logic g);
		if (g !== e)
			value_mismatch(name, {63'b0, e}, {63'b0, g});
	endtask

	// Data is only meaningful when the instruction writes a register.
	task automatic check_retire(input rv64_pkg::retire_t e, input rv64_pkg::retire_t g);
		if (g.pc !== e.pc)
			value_mismatch("out_pc", e.pc, g.pc);
		if (g.rd !== e.rd)
			value_mismatch("out_rd", {59'b0, e.rd}, {59'b0, g.rd});
		check_flag("out_we", e.we, g.we);
		check_flag("out_illegal", e.illegal, g.illegal);
		if (g.next_pc !== e.next_pc)
			value_mismatch("out_next_pc", e.next_pc, g.next_pc);
		if (e.we && g.data !== e.data)
			value_mismatch("out_data", e.data, g.data);
	endtask

	always @(negedge clk) begin
		rv64_pkg::retire_t got;
		if (!reset) begin
			if (cycle == due)
				check_flag("out_valid", 1'b1, out_valid);
			if (out_valid) begin
				got.pc = out_pc;
				got.rd = out_rd;
				got.we = out_we;
				got.data = out_data;
				got.next_pc = out_next_pc;
				got.illegal = out_illegal;
				if (exp_q.size() == 0) begin
					other_err++;
					$display("A retire at pc %h came with no instruction pending.", out_pc);
				end else begin
					check_retire(exp_q.pop_front(), got);
				end
				retired_n++;
			end
		end
	end

	// ============================================================
	// Stimulus.
	// ============================================================
	function automatic logic [31:0] pick_instr();
		logic [31:0] r, r2;
		logic [4:0] m, rd, rs1, rs2;
		logic [2:0] f3, fw;
		logic [11:0] imm;
		r = next_rand();
		r2 = next_rand();
		m = r[21] ? 5'h1f : 5'h07;
		rd = r[4:0] & m;
		rs1 = r[9:5] & m;
		rs2 = r[14:10] & m;
		f3 = r[17:15];
		fw = (r[19:18] == 2'd0) ? 3'd0 : (r[19:18] == 2'd1) ? 3'd1 : 3'd5;
		imm = r2[11:0];
		if (f3 == 3'd1)
			imm = {6'b0, imm[5:0]};
		else if (f3 == 3'd5)
			imm = {r[18] ? 6'b010000 : 6'b0, imm[5:0]};
		case (r[31:28])
			4'd0, 4'd1, 4'd15: return {imm, rs1, f3, rd, `OPC_OP_IMM};
			4'd2: return {fw == 3'd0 ? r2[11:5] : (r[20] && fw == 3'd5) ? 7'b0100000 : 7'b0,
			              r2[4:0], rs1, fw, rd, `OPC_OP_IMM_32};
			4'd3, 4'd4: return {(r[18] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0,
			                    rs2, rs1, f3, rd, `OPC_OP};
			4'd5: return {(r[20] && fw != 3'd1) ? 7'b0100000 : 7'b0, rs2, rs1, fw, rd, `OPC_OP_32};
			4'd6: return {r2[31:12], rd, `OPC_LUI};
			4'd7: return {r2[31:12], rd, `OPC_AUIPC};
			4'd8: return {r2[31:12], rd, `OPC_JAL};
			4'd9: return {imm, rs1, 3'b000, rd, `OPC_JALR};
			4'd10, 4'd11: return {r2[31:25], rs2, rs1, (f3[2:1] == 2'b01) ? f3 ^ 3'b110 : f3,
			                      r2[11:7], `OPC_BRANCH};
			4'd12, 4'd13: return {7'b0000001, rs2, rs1, 3'b000, rd, r[18] ? `OPC_OP_32 : `OPC_OP};
			default: begin
				case (r[19:18])
					2'd0: return {r2[31:7], `OPC_LOAD};
					2'd1: return {r2[31:7], `OPC_STORE};
					2'd2: return {r2[31:7], `OPC_SYSTEM};
					default: return {7'b0000001, rs2, rs1, (f3 == 3'd0) ? 3'd3 : f3, rd, `OPC_OP};
				endcase
			end
		endcase
	endfunction

	// Called at a falling edge; holds the instruction until the slice takes it.
	task automatic send(input logic [31:0] ins);
		int waited;
		logic done;
		logic is_mul;
		waited = 0;
		done = 1'b0;
		is_mul = ins[25] && ins[14:12] == 3'd0 &&
		         (ins[6:0] == `OPC_OP || ins[6:0] == `OPC_OP_32);
		seq++;
		in_valid = 1'b1;
		in_instr = ins;
		in_pc = {next_rand(), seq[29:0], 2'b00};
		while (!done && !stop) begin
			#4;
			if (in_ready) begin
				done = 1'b1;
				if (accepted_n == retired_n && !is_mul)
					due = cycle + 2;
				exp_q.push_back(model_exec(ins, in_pc));
				accepted_n++;
			end else if (waited >= 200) begin
				other_err++;
				$display("The slice did not accept instruction %h within 200 cycles.", ins);
				stop = 1;
			end
			waited++;
			@(negedge clk);
		end
	endtask

	initial begin
		int waited;
		int gap;
		logic [31:0] fill;
		regs[0] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 1; i < 32; i++) begin
			fill = next_rand();
			send({fill[31:20], 5'd0, 3'b000, 5'(i), `OPC_OP_IMM});
		end
		for (int n = 0; n < 600 && !stop; n++) begin
			send(pick_instr());
			gap = (next_rand() % 4 == 0) ? int'(next_rand() % 3) : 0;
			if (gap > 0) begin
				in_valid = 1'b0;
				repeat (gap) @(negedge clk);
			end
		end
		in_valid = 1'b0;
		waited = 0;
		while (exp_q.size() != 0 && !stop) begin
			if (waited >= 200) begin
				other_err++;
				$display("Retires stopped with %0d instructions still pending.", exp_q.size());
				stop = 1;
			end
			waited++;
			@(negedge clk);
		end
		repeat (3) @(negedge clk);
		$display("value errors: %0d, other errors: %0d", value_err, other_err);
		if (value_err == 0 && other_err == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== dv/rv64_slice_properties.sv ====
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_slice_properties (
	input logic             clk,
	input logic             reset,
	input logic             in_ready,
	input logic             out_valid,
	input logic [`XLEN-1:0] out_pc,
	input logic             out_we,
	input logic [4:0]       out_rd
);

	// The input stays closed for the whole reset.
	ready_in_reset: assert property (@(posedge clk) (reset && $past(reset)) |-> !in_ready)
		else $error("in_ready high during reset");

	// Each retire is a single pulse.
	single_retire: assert property (@(posedge clk) disable iff (reset)
		(out_valid && $past(out_valid)) |-> (out_pc != $past(out_pc)))
		else $error("same retire seen twice");

	no_x0_write: assert property (@(posedge clk) disable iff (reset)
		(out_valid && out_we) |-> (out_rd != 5'd0))
		else $error("write to x0 reported");

endmodule

bind rv64_slice rv64_slice_properties props_i (
	.clk       (clk),
	.reset     (reset),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_pc    (out_pc),
	.out_we    (out_we),
	.out_rd    (out_rd)
);

// ==== source/rv64_slice.sv ====
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_slice (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_valid,
	input  logic [31:0]      in_instr,
	input  logic [`XLEN-1:0] in_pc,
	output logic             in_ready,
	output logic             out_valid,
	output logic [`XLEN-1:0] out_pc,
	output logic [4:0]       out_rd,
	output logic             out_we,
	output logic [`XLEN-1:0] out_data,
	output logic [`XLEN-1:0] out_next_pc,
	output logic             out_illegal
);

	rv64_pkg::decoded_t dec;
	rv64_pkg::issue_t   iss_in;
	rv64_pkg::issue_t   iss_q;
	rv64_pkg::retire_t  ret_d;
	rv64_pkg::retire_t  ret_q;
	logic [`XLEN-1:0]   rs1_data;
	logic [`XLEN-1:0]   rs2_data;
	logic               hazard;
	logic               issue_fire;
	logic               iss_valid;
	logic               iss_ready;
	logic               ret_valid;

	rv64_mul_if mul_bus ();

	// ============================================================
	// Decode and operand read.
	// ============================================================
	rv64_decode decode_i (
		.instr (in_instr),
		.dec   (dec)
	);

	assign issue_fire = in_valid && in_ready;
	assign iss_in     = '{dec: dec, pc: in_pc, rs1_val: rs1_data, rs2_val: rs2_data};

	rv64_regfile regfile_i (
		.clk        (clk),
		.reset      (reset),
		.rd_dec     (dec),
		.issue_fire (issue_fire),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.hazard     (hazard),
		.wb_valid   (out_valid),
		.wb_rd      (ret_q.rd),
		.wb_we      (ret_q.we),
		.wb_data    (ret_q.data)
	);

	// ============================================================
	// Issue, execute and retire.
	// ============================================================
	rv64_stage_reg #(.payload_t(rv64_pkg::issue_t)) issue_reg (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (iss_in),
		.block     (hazard),
		.in_ready  (in_ready),
		.out_valid (iss_valid),
		.out_data  (iss_q),
		.out_ready (iss_ready)
	);

	rv64_execute execute_i (
		.clk       (clk),
		.reset     (reset),
		.iss_valid (iss_valid),
		.iss       (iss_q),
		.iss_ready (iss_ready),
		.ret_valid (ret_valid),
		.ret       (ret_d),
		.mul       (mul_bus.ctrl)
	);

	rv64_mul mul_i (
		.clk   (clk),
		.reset (reset),
		.mul   (mul_bus.unit)
	);

	// The output side takes no back-pressure.
	rv64_stage_reg #(.payload_t(rv64_pkg::retire_t)) retire_reg (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (ret_valid),
		.in_data   (ret_d),
		.block     (1'b0),
		.in_ready  (),
		.out_valid (out_valid),
		.out_data  (ret_q),
		.out_ready (1'b1)
	);

	assign out_pc      = ret_q.pc;
	assign out_rd      = ret_q.rd;
	assign out_we      = ret_q.we;
	assign out_data    = ret_q.data;
	assign out_next_pc = ret_q.next_pc;
	assign out_illegal = ret_q.illegal;

endmodule

// ==== source/rv64_execute.sv ====
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_execute (
	input  logic              clk,
	input  logic              reset,
	input  logic              iss_valid,
	input  rv64_pkg::issue_t  iss,
	output logic              iss_ready,
	output logic              ret_valid,
	output rv64_pkg::retire_t ret,
	rv64_mul_if.ctrl          mul
);

	logic [`XLEN-1:0] op1;
	logic [`XLEN-1:0] op2;
	logic [`XLEN-1:0] alu_res;
	logic [31:0]      w_res;
	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] br_target;
	logic             taken;
	logic             is_mul;
	logic             mul_wait;

	assign op1       = (iss.dec.v1_sel == `V1_PC) ? iss.pc : iss.rs1_val;
	assign op2       = (iss.dec.v2_sel == `V2_IMM) ? iss.dec.imm : iss.rs2_val;
	assign pc_plus4  = iss.pc + `XLEN'd4;
	assign br_target = iss.pc + iss.dec.imm;
	assign is_mul    = (iss.dec.cls == rv64_pkg::CLS_MUL);

	// ============================================================
	// ALU, with 32-bit results for the word forms.
	// ============================================================
	always_comb begin
		case (iss.dec.alu_op)
			rv64_pkg::ALU_SUB:  alu_res = op1 - op2;
			rv64_pkg::ALU_SLL:  alu_res = op1 << op2[5:0];
			rv64_pkg::ALU_SLT:  alu_res = {63'b0, $signed(op1) < $signed(op2)};
			rv64_pkg::ALU_SLTU: alu_res = {63'b0, op1 < op2};
			rv64_pkg::ALU_XOR:  alu_res = op1 ^ op2;
			rv64_pkg::ALU_SRL:  alu_res = op1 >> op2[5:0];
			rv64_pkg::ALU_SRA:  alu_res = $signed(op1) >>> op2[5:0];
			rv64_pkg::ALU_OR:   alu_res = op1 | op2;
			rv64_pkg::ALU_AND:  alu_res = op1 & op2;
			default:            alu_res = op1 + op2;
		endcase
		case (iss.dec.alu_op)
			rv64_pkg::ALU_SUB: w_res = op1[31:0] - op2[31:0];
			rv64_pkg::ALU_SLL: w_res = op1[31:0] << op2[4:0];
			rv64_pkg::ALU_SRL: w_res = op1[31:0] >> op2[4:0];
			rv64_pkg::ALU_SRA: w_res = $signed(op1[31:0]) >>> op2[4:0];
			default:           w_res = op1[31:0] + op2[31:0];
		endcase
	end

	always_comb begin
		case (iss.dec.func3)
			`F3_BEQ:  taken = (iss.rs1_val == iss.rs2_val);
			`F3_BNE:  taken = (iss.rs1_val != iss.rs2_val);
			`F3_BLT:  taken = ($signed(iss.rs1_val) < $signed(iss.rs2_val));
			`F3_BGE:  taken = ($signed(iss.rs1_val) >= $signed(iss.rs2_val));
			`F3_BLTU: taken = (iss.rs1_val < iss.rs2_val);
			`F3_BGEU: taken = (iss.rs1_val >= iss.rs2_val);
			default:  taken = 1'b0;
		endcase
	end

	// ============================================================
	// Multiplier handshake. Start fires once per multiply.
	// ============================================================
	always_ff @(posedge clk) begin
		if (reset)
			mul_wait <= 1'b0;
		else if (mul.start)
			mul_wait <= 1'b1;
		else if (mul.done)
			mul_wait <= 1'b0;
	end

	assign mul.start = iss_valid && is_mul && !mul_wait && !mul.busy;
	assign mul.a     = iss.rs1_val;
	assign mul.b     = iss.rs2_val;
	assign mul.word  = iss.dec.word;

	assign iss_ready = !is_mul || mul.done;
	assign ret_valid = iss_valid && iss_ready;

	always_comb begin
		ret.pc      = iss.pc;
		ret.rd      = iss.dec.rd;
		ret.we      = iss.dec.writes_rd && (iss.dec.rd != 5'd0);
		ret.illegal = (iss.dec.cls == rv64_pkg::CLS_ILLEGAL);
		ret.next_pc = pc_plus4;
		if (iss.dec.cls == rv64_pkg::CLS_JUMP)
			ret.data = pc_plus4;
		else if (is_mul)
			ret.data = mul.product;
		else if (iss.dec.word)
			ret.data = {{32{w_res[31]}}, w_res};
		else
			ret.data = alu_res;
		if (iss.dec.cls == rv64_pkg::CLS_BRANCH && taken)
			ret.next_pc = br_target;
		else if (iss.dec.cls == rv64_pkg::CLS_JUMP)
			ret.next_pc = (iss.dec.opcode == `OPC_JALR) ? {alu_res[`XLEN-1:1], 1'b0} : alu_res;
	end

endmodule

// ==== source/rv64_mul.sv ====
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_mul (
	input logic      clk,
	input logic      reset,
	rv64_mul_if.unit mul
);

	logic [`XLEN-1:0] acc;
	logic [`XLEN-1:0] acc_next;
	logic [`XLEN-1:0] mcand;
	logic [`XLEN-1:0] mplier;
	logic [6:0]       count;
	logic             word_q;
	logic             busy_q;
	logic             done_q;

	// One partial product per cycle, taken from the low multiplier bit.
	assign acc_next = acc + (mplier[0] ? mcand : '0);

	// ============================================================
	// Iteration control.
	// ============================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			count  <= '0;
		end else begin
			done_q <= 1'b0;
			if (mul.start) begin
				busy_q <= 1'b1;
				count  <= mul.word ? 7'd32 : 7'd64;
			end else if (busy_q) begin
				count <= count - 7'd1;
				// The last step lands together with done.
				if (count == 7'd1) begin
					busy_q <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mul.start) begin
			acc    <= '0;
			mcand  <= mul.a;
			mplier <= mul.word ? {32'b0, mul.b[31:0]} : mul.b;
			word_q <= mul.word;
		end else if (busy_q) begin
			acc    <= acc_next;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign mul.busy    = busy_q;
	assign mul.done    = done_q;
	assign mul.product = word_q ? {{32{acc[31]}}, acc[31:0]} : acc;

endmodule

// ==== source/rv64_stage_reg.sv ====
`timescale 1ns/1ps

module rv64_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	input  payload_t in_data,
	input  logic     block,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	logic armed;

	// The slot refuses input until the first edge out of reset.
	assign in_ready = armed && !block && (!out_valid || out_ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			armed     <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			armed <= 1'b1;
			if (in_valid && in_ready)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			out_data <= in_data;
	end

endmodule

// ==== source/rv64_regfile.sv ====
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_regfile (
	input  logic               clk,
	input  logic               reset,
	input  rv64_pkg::decoded_t rd_dec,
	input  logic               issue_fire,
	output logic [`XLEN-1:0]   rs1_data,
	output logic [`XLEN-1:0]   rs2_data,
	output logic               hazard,
	input  logic               wb_valid,
	input  logic [4:0]         wb_rd,
	input  logic               wb_we,
	input  logic [`XLEN-1:0]   wb_data
);

	logic [`XLEN-1:0] regs [32];
	logic [31:0]      busy;

	// Reads see the array as of the last edge; there is no bypass.
	assign rs1_data = (rd_dec.rs1 == 5'd0) ? '0 : regs[rd_dec.rs1];
	assign rs2_data = (rd_dec.rs2 == 5'd0) ? '0 : regs[rd_dec.rs2];

	always_ff @(posedge clk) begin
		if (wb_valid && wb_we && wb_rd != 5'd0)
			regs[wb_rd] <= wb_data;
	end

	// ============================================================
	// Scoreboard. One busy bit per architectural register.
	// ============================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
		end else begin
			if (wb_valid && wb_we)
				busy[wb_rd] <= 1'b0;
			if (issue_fire && rd_dec.writes_rd && rd_dec.rd != 5'd0)
				busy[rd_dec.rd] <= 1'b1;
		end
	end

	// Stall on any pending source, and on a pending destination to keep retire order.
	assign hazard = (rd_dec.uses_rs1 && busy[rd_dec.rs1]) ||
	                (rd_dec.uses_rs2 && busy[rd_dec.rs2]) ||
	                (rd_dec.writes_rd && busy[rd_dec.rd]);

endmodule

// ==== source/rv64_decode.sv ====
`timescale 1ns/1ps
`include "rv64_consts.svh"

module rv64_decode (
	input  logic [31:0]        instr,
	output rv64_pkg::decoded_t dec
);

	logic [6:0]       opc;
	logic [2:0]       f3;
	logic             i_fmt;
	logic             u_fmt;
	logic             j_fmt;
	logic             b_fmt;
	logic             s_fmt;
	logic             r_fmt;
	logic             legal;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_s;

	// Maps an ALU func3 to its operation; alt picks SUB or SRA.
	function automatic rv64_pkg::alu_op_e alu_from_f3(input logic [2:0] code, input logic alt);
		case (code)
			`F3_ADD:  return alt ? rv64_pkg::ALU_SUB : rv64_pkg::ALU_ADD;
			`F3_SLL:  return rv64_pkg::ALU_SLL;
			`F3_SLT:  return rv64_pkg::ALU_SLT;
			`F3_SLTU: return rv64_pkg::ALU_SLTU;
			`F3_XOR:  return rv64_pkg::ALU_XOR;
			`F3_SRL:  return alt ? rv64_pkg::ALU_SRA : rv64_pkg::ALU_SRL;
			`F3_OR:   return rv64_pkg::ALU_OR;
			default:  return rv64_pkg::ALU_AND;
		endcase
	endfunction

	assign opc = instr[6:0];
	assign f3  = instr[14:12];

	assign i_fmt = (opc == `OPC_JALR) || (opc == `OPC_LOAD) || (opc == `OPC_OP_IMM) ||
	               (opc == `OPC_OP_IMM_32);
	assign u_fmt = (opc == `OPC_LUI) || (opc == `OPC_AUIPC);
	assign j_fmt = (opc == `OPC_JAL);
	assign b_fmt = (opc == `OPC_BRANCH);
	assign s_fmt = (opc == `OPC_STORE);
	assign r_fmt = (opc == `OPC_OP) || (opc == `OPC_OP_32);

	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
	assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};

	always_comb begin
		dec.opcode = opc;
		dec.func3  = f3;
		dec.func7  = instr[30];
		// LUI reads x0 so that its add yields the bare immediate.
		dec.rs1    = (opc == `OPC_LUI) ? 5'd0 : instr[19:15];
		dec.rs2    = instr[24:20];
		dec.rd     = instr[11:7];
		dec.imm    = i_fmt ? imm_i :
		             u_fmt ? imm_u :
		             j_fmt ? imm_j :
		             b_fmt ? imm_b :
		             s_fmt ? imm_s : '0;
		dec.v1_sel = (j_fmt || opc == `OPC_AUIPC) ? `V1_PC : `V1_RS1;
		dec.v2_sel = (r_fmt || b_fmt) ? `V2_RS2 : `V2_IMM;
		dec.mul_en = r_fmt && instr[25];
		dec.word   = (opc == `OPC_OP_IMM_32) || (opc == `OPC_OP_32);
		dec.cls    = rv64_pkg::CLS_ILLEGAL;
		dec.alu_op = rv64_pkg::ALU_ADD;

		case (opc)
			`OPC_LUI, `OPC_AUIPC: dec.cls = rv64_pkg::CLS_ALU;
			`OPC_JAL:             dec.cls = rv64_pkg::CLS_JUMP;
			`OPC_JALR: begin
				if (f3 == 3'b000)
					dec.cls = rv64_pkg::CLS_JUMP;
			end
			`OPC_BRANCH: begin
				if (f3[2:1] != 2'b01)
					dec.cls = rv64_pkg::CLS_BRANCH;
			end
			`OPC_OP_IMM, `OPC_OP_IMM_32: begin
				dec.alu_op = alu_from_f3(f3, (f3 == `F3_SRL) && instr[30]);
				// Shifts carry a shamt in the upper bits, so only those are checked.
				if (f3 != `F3_SLL && f3 != `F3_SRL && opc == `OPC_OP_IMM)
					dec.cls = rv64_pkg::CLS_ALU;
				else if ((f3 == `F3_SLL || f3 == `F3_SRL) &&
				         (instr[31:26] == 6'b0 ||
				          (f3 == `F3_SRL && instr[31:26] == 6'b010000)) &&
				         (opc == `OPC_OP_IMM || !instr[25]))
					dec.cls = rv64_pkg::CLS_ALU;
				else if (f3 == `F3_ADD)
					dec.cls = rv64_pkg::CLS_ALU;
			end
			`OPC_OP, `OPC_OP_32: begin
				if (instr[25]) begin
					// Only MUL and MULW exist in this slice.
					if (f3 == 3'b000 && instr[31:26] == 6'b0) begin
						dec.cls    = rv64_pkg::CLS_MUL;
						dec.alu_op = rv64_pkg::ALU_MUL;
					end
				end else begin
					dec.alu_op = alu_from_f3(f3, instr[30]);
					if ((instr[31:25] == 7'b0 ||
					     (instr[31:25] == 7'b0100000 && (f3 == `F3_ADD || f3 == `F3_SRL))) &&
					    (opc == `OPC_OP || f3 == `F3_ADD || f3 == `F3_SLL || f3 == `F3_SRL))
						dec.cls = rv64_pkg::CLS_ALU;
				end
			end
			default: dec.cls = rv64_pkg::CLS_ILLEGAL;
		endcase

		legal = (dec.cls != rv64_pkg::CLS_ILLEGAL);

		dec.uses_rs1  = legal && !(u_fmt || j_fmt);
		dec.uses_rs2  = legal && (r_fmt || b_fmt);
		dec.writes_rd = legal && !b_fmt;
	end

endmodule

// ==== source/rv64_mul_if.sv ====
`timescale 1ns/1ps
`include "rv64_consts.svh"

// Request and result lines between the execute unit and the multiplier.
interface rv64_mul_if;
	logic             start;
	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic             word;
	logic             busy;
	logic             done;
	logic [`XLEN-1:0] product;

	modport ctrl (
		output start,
		output a,
		output b,
		output word,
		input  busy,
		input  done,
		input  product
	);

	modport unit (
		input  start,
		input  a,
		input  b,
		input  word,
		output busy,
		output done,
		output product
	);
endinterface

// ==== source/rv64_pkg.sv ====
`include "rv64_consts.svh"

package rv64_pkg;

	// ============================================================
	// Operation and class encodings.
	// ============================================================
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_MUL
	} alu_op_e;

	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_BRANCH,
		CLS_JUMP,
		CLS_MUL,
		CLS_ILLEGAL
	} instr_class_e;

	// ============================================================
	// Pipeline payloads.
	// ============================================================
	typedef struct packed {
		logic [6:0]        opcode;
		logic [2:0]        func3;
		logic              func7;
		logic [4:0]        rs1;
		logic [4:0]        rs2;
		logic [4:0]        rd;
		logic [`XLEN-1:0]  imm;
		logic              v1_sel;
		logic              v2_sel;
		logic              mul_en;
		logic              word;
		instr_class_e      cls;
		alu_op_e           alu_op;
		logic              uses_rs1;
		logic              uses_rs2;
		logic              writes_rd;
	} decoded_t;

	// What sits in the issue slot: the decode plus its operands.
	typedef struct packed {
		decoded_t          dec;
		logic [`XLEN-1:0]  pc;
		logic [`XLEN-1:0]  rs1_val;
		logic [`XLEN-1:0]  rs2_val;
	} issue_t;

	typedef struct packed {
		logic [`XLEN-1:0]  pc;
		logic [4:0]        rd;
		logic              we;
		logic [`XLEN-1:0]  data;
		logic [`XLEN-1:0]  next_pc;
		logic              illegal;
	} retire_t;

endpackage

// ==== source/rv64_consts.svh ====
`ifndef RV64_CONSTS_SVH
`define RV64_CONSTS_SVH

// ============================================================
// Data width of the integer datapath.
// ============================================================
`define XLEN 64

// ============================================================
// Major opcodes, instr[6:0].
// ============================================================
`define OPC_LUI       7'b0110111
`define OPC_AUIPC     7'b0010111
`define OPC_JAL       7'b1101111
`define OPC_JALR      7'b1100111
`define OPC_BRANCH    7'b1100011
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_OP_IMM    7'b0010011
`define OPC_OP_IMM_32 7'b0011011
`define OPC_OP        7'b0110011
`define OPC_OP_32     7'b0111011
`define OPC_SYSTEM    7'b1110011

// ALU func3 codes. SUB and SRA share their slot with ADD and SRL.
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SRL  3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

// Branch func3 codes.
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// Operand select codes.
`define V1_RS1 1'b0
`define V1_PC  1'b1
`define V2_RS2 1'b0
`define V2_IMM 1'b1

`endif
